/* Makefile */
# Verilator build for the pooling core and its testbench

OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f squeeze_core.f --top-module sq_top

sim:
	verilator --binary --timing -f squeeze_core.f --top-module tb_sq_top \
		--Mdir $(OBJ) -o sim_tb
	./$(OBJ)/sim_tb | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* dv/sq_cases.txt */
# op win_log p0 p1 p2 p3 p4 p5 p6 p7 expected, all hex
# op 0 is max pooling, op 1 is average pooling, window is 1 << win_log
0 0 1234 0000 0000 0000 0000 0000 0000 0000 1234
1 0 abcd 0000 0000 0000 0000 0000 0000 0000 abcd
0 1 0010 0020 0000 0000 0000 0000 0000 0000 0020
1 1 0003 0004 0000 0000 0000 0000 0000 0000 0003
0 2 0100 ffff 7fff 8000 0000 0000 0000 0000 ffff
1 2 0001 0002 0003 0004 0000 0000 0000 0000 0002
1 2 ffff ffff ffff ffff 0000 0000 0000 0000 ffff
0 3 0001 0009 0003 0008 0002 0007 0004 0005 0009
1 3 ffff ffff ffff ffff ffff ffff ffff ffff ffff
1 3 0001 0002 0003 0004 0005 0006 0007 0008 0004
1 3 8000 8000 8000 8000 0000 0000 0000 0001 4000
0 3 0000 0000 0000 0000 0000 0000 0000 0000 0000
1 1 ffff 0001 0000 0000 0000 0000 0000 0000 8000
0 1 c000 bfff 0000 0000 0000 0000 0000 0000 c000

/* dv/tb_sq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module tb_sq_top
	import sq_pkg::*;
();

	typedef struct packed {
		op_type_e   op;
		win_log_t   wl;
		pix_t [7:0] px;                    // Unused entries are zero
		pix_t       exp;
	} pool_case_t;

	logic  okClk;
	logic  reset;
	logic  psel;
	logic  penable;
	logic  pwrite;
	word_t paddr;
	word_t pwdata;
	word_t prdata;
	logic  pready;
	logic  pslverr;
	logic  irq;

	int          err_cnt;
	int          pass_cnt;
	int          fail_cnt;
	int          test_err0;
	string       test_name;
	int          n_file;
	logic        cases_loaded;
	done_cnt_t   exp_done;                 // Model of the completion count
	done_cnt_t   irq_cnt;                  // Interrupt pulses seen
	int unsigned lcg_state;
	pool_case_t  cases[$];

	sq_top dut (
		.okClk   (okClk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.irq     (irq)
	);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;
	end

	// One count per cycle of irq high
	always @(negedge okClk) begin
		if (reset)
			irq_cnt <= '0;
		else if (irq === 1'b1)
			irq_cnt <= irq_cnt + 8'd1;
	end

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Window max, or the truncated mean
	function automatic pix_t expected_result(input pool_case_t c);
		int   sum;
		pix_t mx;
		int   i;
		sum = 0;
		mx  = '0;
		for (i = 0; i < (1 << c.wl); i++) begin
			sum = sum + int'(c.px[i]);
			if (c.px[i] > mx)
				mx = c.px[i];
		end
		return (c.op == OP_AVEPOOL) ? pix_t'(sum >> c.wl) : mx;
	endfunction

	task automatic apb_write(input word_t addr, input word_t data, output logic err);
		@(posedge okClk);
		psel    <= 1'b1;                   // Setup phase
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge okClk);
		penable <= 1'b1;
		@(negedge okClk);
		err = pslverr;
		check_err("pready", pready, 1'b1);
		@(posedge okClk);                  // Write lands on this edge
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input word_t addr, output word_t data, output logic err);
		@(posedge okClk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge okClk);
		penable <= 1'b1;
		@(negedge okClk);
		data = prdata;                     // Mid access phase
		err  = pslverr;
		check_err("pready", pready, 1'b1);
		@(posedge okClk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_pix(input string name, input pix_t got, input pix_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_stat(input string name, input stat_t got, input stat_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_count(input string name, input done_cnt_t got,
		input done_cnt_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_err0) begin
			$display("test %s: ok", test_name);
			pass_cnt = pass_cnt + 1;
		end else begin
			$display("test %s: %0d errors", test_name, err_cnt - test_err0);
			fail_cnt = fail_cnt + 1;
		end
	endtask

	task automatic verify_status(input logic res_empty, input logic res_block,
		input logic pix_space);
		word_t rd;
		logic  err;
		stat_t got;
		stat_t exp;
		apb_read(`SQ_ADDR_STAT, rd, err);
		check_err("STAT pslverr", err, 1'b0);
		got           = stat_t'({rd[23:16], rd[2:0]});
		exp.done_cnt  = exp_done;
		exp.res_empty = res_empty;
		exp.res_block = res_block;
		exp.pix_space = pix_space;
		check_stat("STATUS", got, exp);
		check_count("irq pulses", irq_cnt, exp_done);
	endtask

	task automatic poll_status(input int idx, input logic val, output logic ok);
		int    polls;
		word_t rd;
		logic  err;
		ok = 1'b0;
		for (polls = 0; polls < 100 && !ok; polls++) begin
			apb_read(`SQ_ADDR_STAT, rd, err);
			ok = (rd[idx] == val);
		end
		if (!ok) begin
			$display("STATUS bit %0d never reached %0d in 100 polls", idx, val);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic send_cmd(input op_type_e op, input win_log_t wl);
		logic err;
		apb_write(`SQ_ADDR_CMD, word_t'({wl, op}), err);
		check_err("CMD pslverr", err, 1'b0);
	endtask

	task automatic send_pixels(input pool_case_t c, input int lo, input int hi);
		int   i;
		logic err;
		for (i = lo; i <= hi; i++) begin
			apb_write(`SQ_ADDR_PIX, word_t'(c.px[i]), err);
			check_err("PIX pslverr", err, 1'b0);
		end
	endtask

	task automatic collect_result(input pool_case_t c);
		word_t rd;
		logic  err;
		logic  ok;
		poll_status(2, 1'b0, ok);          // Wait for res_empty low
		if (ok) begin
			apb_read(`SQ_ADDR_RES, rd, err);
			check_err("RES pslverr", err, 1'b0);
			check_pix("RES data", rd[15:0], c.exp);
		end
		exp_done = exp_done + 8'd1;
	endtask

	task automatic run_case(input pool_case_t c);
		send_cmd(c.op, c.wl);
		send_pixels(c, 0, (1 << c.wl) - 1);
		collect_result(c);
		verify_status(1'b1, 1'b0, 1'b1);
	endtask

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	initial begin
		wait (cases_loaded === 1'b1);
		repeat ((n_file + 8) * 400 + 2000) @(posedge okClk);
		$display("Watchdog expired, the run timed out");
		$display("Result: FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int          fd;
		string       line;
		int          v[11];
		pool_case_t  c;
		pool_case_t  burst[4];
		int unsigned r;
		int          i;
		int          k;
		word_t       rd;
		logic        err;
		logic        ok;

		reset   <= 1'b1;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		err_cnt      = 0;
		pass_cnt     = 0;
		fail_cnt     = 0;
		exp_done     = '0;
		lcg_state    = 58619;
		cases_loaded = 1'b0;

		fd = $fopen("dv/sq_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/sq_cases.txt");
			err_cnt = err_cnt + 1;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
					v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]) == 11) begin
					c.op = op_type_e'(v[0][1:0]);
					c.wl = v[1][1:0];
					for (k = 0; k < 8; k++)
						c.px[k] = v[k + 2][15:0];
					c.exp = v[10][15:0];
					cases.push_back(c);
				end
			end
			$fclose(fd);
			if (cases.size() == 0) begin
				$display("No cases found in dv/sq_cases.txt");
				err_cnt = err_cnt + 1;
			end
		end
		n_file = cases.size();

		for (i = 0; i < 8; i++) begin
			c    = '0;
			r    = lcg_next();
			c.op = r[16] ? OP_AVEPOOL : OP_MAXPOOL;
			c.wl = r[21:20];
			for (k = 0; k < (1 << c.wl); k++)
				c.px[k] = pix_t'(lcg_next() >> 12);
			c.exp = expected_result(c);
			cases.push_back(c);
		end
		cases_loaded = 1'b1;

		repeat (10) @(posedge okClk);
		reset <= 1'b0;
		@(posedge okClk);

		begin_test("status after reset");
		verify_status(1'b1, 1'b0, 1'b1);
		end_test();

		for (i = 0; i < cases.size(); i++) begin
			if (i < n_file)
				begin_test($sformatf("file case %0d", i));
			else
				begin_test($sformatf("random case %0d", i - n_file));
			run_case(cases[i]);
			end_test();
		end

		begin_test("reserved opcodes");
		c    = '0;
		c.op = OP_AVEPOOL;
		c.wl = 2'd2;
		c.px[0] = 16'd10;
		c.px[1] = 16'd20;
		c.px[2] = 16'd30;
		c.px[3] = 16'd41;
		c.exp   = expected_result(c);
		send_cmd(OP_RSVD2, 2'd1);          // Dropped by the control block
		send_cmd(OP_RSVD3, 2'd3);
		run_case(c);                       // Only one completion counted
		end_test();

		begin_test("pixel throttle");
		c    = '0;
		c.op = OP_MAXPOOL;
		c.wl = 2'd3;
		for (k = 0; k < 8; k++)
			c.px[k] = pix_t'(16'h0500 + ((k * 7) % 8) * 16'h0011);
		c.exp = expected_result(c);
		send_pixels(c, 0, 6);              // Seven queued, above the limit of 6
		verify_status(1'b1, 1'b0, 1'b0);
		send_cmd(c.op, c.wl);
		send_pixels(c, 7, 7);
		collect_result(c);
		verify_status(1'b1, 1'b0, 1'b1);
		end_test();

		begin_test("result block and errors");
		for (i = 0; i < 4; i++) begin
			burst[i]       = '0;
			burst[i].op    = OP_MAXPOOL;
			burst[i].wl    = 2'd1;
			burst[i].px[0] = pix_t'(16'h0100 + i);
			burst[i].px[1] = pix_t'(16'h0300 - i * 16'h0101);
			burst[i].exp   = expected_result(burst[i]);
			send_cmd(burst[i].op, burst[i].wl);
			send_pixels(burst[i], 0, 1);
		end
		poll_status(1, 1'b1, ok);          // Wait for res_block
		exp_done = exp_done + 8'd4;
		verify_status(1'b0, 1'b1, 1'b1);
		for (i = 0; i < 4; i++) begin
			apb_read(`SQ_ADDR_RES, rd, err);
			check_err("RES pslverr", err, 1'b0);
			check_pix("RES data", rd[15:0], burst[i].exp);
		end
		verify_status(1'b1, 1'b0, 1'b1);
		apb_read(`SQ_ADDR_RES, rd, err);   // Empty read
		check_err("RES empty pslverr", err, 1'b1);
		check_pix("RES empty data", rd[15:0], 16'h0000);
		apb_read(32'h0000_0010, rd, err);
		check_err("unmapped read pslverr", err, 1'b1);
		apb_write(32'h0000_0010, 32'h0000_0001, err);
		check_err("unmapped write pslverr", err, 1'b1);
		end_test();

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/apb_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module apb_host_port
	import sq_pkg::*;
(
	input  logic                                okClk,
	input  logic                                reset,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  word_t                               paddr,
	input  word_t                               pwdata,
	output word_t                               prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic                                cmd_push,
	output op_cmd_t                             cmd_data,
	input  logic                                cmd_full,
	output logic                                pix_push,
	output pix_t                                pix_data,
	input  logic                                pix_full,
	input  logic [$clog2(`SQ_PIX_DEPTH+1)-1:0]  pix_count,
	output logic                                res_pop,
	input  pix_t                                res_data,
	input  logic                                res_empty,
	input  logic [$clog2(`SQ_RES_DEPTH+1)-1:0]  res_count,
	input  done_cnt_t                           done_cnt
);

	localparam int PIX_CW    = $clog2(`SQ_PIX_DEPTH + 1);
	localparam int RES_CW    = $clog2(`SQ_RES_DEPTH + 1);
	localparam int PIX_LIMIT = `SQ_PIX_DEPTH - `SQ_HEADROOM - `SQ_IN_BLOCK;

	logic  access;
	logic  pix_space;
	logic  res_block;
	stat_t stat;

	assign access  = psel && penable;
	assign pready  = 1'b1;                 // Zero wait states

	assign cmd_data.op_type = op_type_e'(pwdata[1:0]);
	assign cmd_data.win_log = pwdata[3:2];
	assign pix_data         = pwdata[`SQ_PIX_W-1:0];

	assign stat.done_cnt  = done_cnt;
	assign stat.res_empty = res_empty;
	assign stat.res_block = res_block;
	assign stat.pix_space = pix_space;

	// --------------------------------------------------
	// Access phase decode
	// --------------------------------------------------
	always_comb begin
		cmd_push = 1'b0;
		pix_push = 1'b0;
		res_pop  = 1'b0;
		pslverr  = 1'b0;
		prdata   = '0;
		if (access) begin
			case (paddr)
				`SQ_ADDR_CMD: begin
					if (pwrite && !cmd_full)
						cmd_push = 1'b1;
					else
						pslverr = 1'b1;    // Full, or a read of CMD
				end
				`SQ_ADDR_PIX: begin
					if (pwrite && !pix_full)
						pix_push = 1'b1;
					else
						pslverr = 1'b1;
				end
				`SQ_ADDR_RES: begin
					if (!pwrite && !res_empty) begin
						res_pop = 1'b1;
						prdata  = word_t'(res_data);
					end else begin
						pslverr = 1'b1;    // Empty read returns zero
					end
				end
				`SQ_ADDR_STAT: begin
					if (!pwrite)
						prdata = {8'h00, stat.done_cnt, 13'h0000,
							stat.res_empty, stat.res_block, stat.pix_space};
					else
						pslverr = 1'b1;
				end
				default: pslverr = 1'b1;   // Unmapped
			endcase
		end
	end

	// --------------------------------------------------
	// Block throttle
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset) begin
			pix_space <= 1'b1;
			res_block <= 1'b0;
		end else begin
			pix_space <= (pix_count <= PIX_CW'(PIX_LIMIT));       // Room for a block
			res_block <= (res_count >= RES_CW'(`SQ_OUT_BLOCK));   // A block waits
		end
	end

endmodule

`default_nettype wire

/* rtl/csb.sv */
`timescale 1ns/1ps
`default_nettype none

module csb
	import sq_pkg::*;
(
	input  logic      okClk,
	input  logic      reset,
	input  op_cmd_t   cmd,
	input  logic      cmd_empty,
	output logic      cmd_pop,
	output logic      op_valid,
	output op_cmd_t   op,
	input  logic      op_ready,
	input  logic      op_done,
	output done_cnt_t done_cnt,
	output logic      irq
);

	csb_state_e state;
	op_cmd_t    op_reg;
	logic       rsvd;

	assign cmd_pop  = (state == CSB_IDLE) && !cmd_empty;
	assign op_valid = (state == CSB_ISSUE);
	assign op       = op_reg;              // Stable from FETCH to WAIT
	assign irq      = (state == CSB_WAIT) && op_done;
	assign rsvd     = (op_reg.op_type == OP_RSVD2) || (op_reg.op_type == OP_RSVD3);

	always_ff @(posedge okClk) begin
		if (reset) begin
			state    <= CSB_IDLE;
			done_cnt <= '0;
		end else begin
			case (state)
				CSB_IDLE: begin
					if (!cmd_empty)
						state <= CSB_FETCH;
				end
				CSB_FETCH: begin
					// Reserved opcodes are dropped silently
					state <= rsvd ? CSB_IDLE : CSB_ISSUE;
				end
				CSB_ISSUE: begin
					if (op_ready)
						state <= CSB_WAIT;
				end
				CSB_WAIT: begin
					if (op_done) begin
						done_cnt <= done_cnt + 1'b1;   // Wraps at 255
						state    <= CSB_IDLE;
					end
				end
				default: state <= CSB_IDLE;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (cmd_pop)
			op_reg <= cmd;
	end

endmodule

`default_nettype wire

/* rtl/pool_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module pool_engine
	import sq_pkg::*;
(
	input  logic    okClk,
	input  logic    reset,
	input  logic    op_valid,
	input  op_cmd_t op,
	output logic    op_ready,
	input  pix_t    pix,
	input  logic    pix_empty,
	output logic    pix_pop,
	output pix_t    res,
	input  logic    res_full,
	output logic    res_push,
	output logic    op_done
);

	localparam int ACC_W = `SQ_PIX_W + 3;  // Sum of up to 8 pixels

	eng_state_e       state;
	op_cmd_t          op_reg;
	logic [3:0]       remain;              // Pixels still to pop
	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] pix_ext;
	logic [ACC_W-1:0] avg;

	assign op_ready = (state == ENG_IDLE);
	assign pix_pop  = (state == ENG_ACC) && !pix_empty;
	assign res_push = (state == ENG_PUSH) && !res_full;

	assign pix_ext = ACC_W'(pix);
	assign avg     = acc >> op_reg.win_log;   // Truncates the fraction
	assign res     = (op_reg.op_type == OP_AVEPOOL) ? avg[`SQ_PIX_W-1:0]
		: acc[`SQ_PIX_W-1:0];

	always_ff @(posedge okClk) begin
		if (reset) begin
			state   <= ENG_IDLE;
			remain  <= '0;
			op_done <= 1'b0;
		end else begin
			op_done <= res_push;            // One cycle after the push
			case (state)
				ENG_IDLE: begin
					if (op_valid) begin
						remain <= 4'd1 << op.win_log;
						state  <= ENG_ACC;
					end
				end
				ENG_ACC: begin
					if (pix_pop) begin
						remain <= remain - 1'b1;
						if (remain == 4'd1)
							state <= ENG_PUSH;
					end
				end
				ENG_PUSH: begin
					if (!res_full)
						state <= ENG_IDLE;   // Held here by back-pressure
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge okClk) begin
		if (op_valid && op_ready) begin
			op_reg <= op;
			acc    <= '0;
		end else if (pix_pop) begin
			if (op_reg.op_type == OP_AVEPOOL)
				acc <= acc + pix_ext;
			else if (pix_ext > acc)
				acc <= pix_ext;             // Running max
		end
	end

endmodule

`default_nettype wire

/* rtl/sq_params.svh */
`ifndef SQ_PARAMS_SVH
`define SQ_PARAMS_SVH

`define SQ_WORD_W     32           // APB data and address
`define SQ_PIX_W      16           // Pixel and result
`define SQ_CMD_DEPTH  8
`define SQ_PIX_DEPTH  16
`define SQ_RES_DEPTH  8

// Block throttle
`define SQ_IN_BLOCK   8            // Pixels per host block
`define SQ_HEADROOM   2            // Slack for the registered flag
`define SQ_OUT_BLOCK  4            // Results per host block

`define SQ_ADDR_CMD   32'h0000_0000
`define SQ_ADDR_PIX   32'h0000_0004
`define SQ_ADDR_RES   32'h0000_0008
`define SQ_ADDR_STAT  32'h0000_000C

`endif

/* rtl/sq_pkg.sv */
`default_nettype none

`include "sq_params.svh"

package sq_pkg;

	typedef logic [`SQ_WORD_W-1:0] word_t;
	typedef logic [`SQ_PIX_W-1:0]  pix_t;      // Unsigned
	typedef logic [1:0]            win_log_t;  // Window is 1 << win_log pixels
	typedef logic [7:0]            done_cnt_t; // Wraps

	typedef enum logic [1:0] {
		OP_MAXPOOL = 2'd0,
		OP_AVEPOOL = 2'd1,
		OP_RSVD2   = 2'd2,                      // Former conv slots
		OP_RSVD3   = 2'd3
	} op_type_e;

	// Same layout as command word bits 3:0
	typedef struct packed {
		win_log_t win_log;
		op_type_e op_type;
	} op_cmd_t;

	typedef enum logic [1:0] {CSB_IDLE, CSB_FETCH, CSB_ISSUE, CSB_WAIT} csb_state_e;

	typedef enum logic [1:0] {ENG_IDLE, ENG_ACC, ENG_PUSH} eng_state_e;

	typedef struct packed {
		done_cnt_t done_cnt;                    // STATUS 23:16
		logic      res_empty;                   // STATUS 2
		logic      res_block;                   // STATUS 1
		logic      pix_space;                   // STATUS 0
	} stat_t;

endpackage

`default_nettype wire

/* rtl/sq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sq_params.svh"

module sq_top
	import sq_pkg::*;
(
	input  logic  okClk,
	input  logic  reset,
	input  logic  psel,
	input  logic  penable,
	input  logic  pwrite,
	input  word_t paddr,
	input  word_t pwdata,
	output word_t prdata,
	output logic  pready,
	output logic  pslverr,
	output logic  irq
);

	op_cmd_t   cmd_wdata;
	op_cmd_t   cmd_head;
	op_cmd_t   op;
	logic      cmd_push;
	logic      cmd_pop;
	logic      cmd_full;
	logic      cmd_empty;

	pix_t      pix_wdata;
	pix_t      pix_head;
	logic      pix_push;
	logic      pix_pop;
	logic      pix_full;
	logic      pix_empty;
	logic [$clog2(`SQ_PIX_DEPTH+1)-1:0] pix_count;

	pix_t      res;
	pix_t      res_head;
	logic      res_push;
	logic      res_pop;
	logic      res_full;
	logic      res_empty;
	logic [$clog2(`SQ_RES_DEPTH+1)-1:0] res_count;

	done_cnt_t done_cnt;
	logic      op_valid;
	logic      op_ready;
	logic      op_done;

	// --------------------------------------------------
	// Host side queues
	// --------------------------------------------------
	sync_fifo #(.WIDTH($bits(op_cmd_t)), .DEPTH(`SQ_CMD_DEPTH)) cmd_fifo (
		.okClk  (okClk),
		.reset  (reset),
		.push   (cmd_push),
		.wdata  (cmd_wdata),
		.pop    (cmd_pop),
		.rdata  (cmd_head),
		.full   (cmd_full),
		.empty  (cmd_empty),
		.count  ()                        // Not throttled
	);

	sync_fifo #(.WIDTH(`SQ_PIX_W), .DEPTH(`SQ_PIX_DEPTH)) pix_fifo (
		.okClk  (okClk),
		.reset  (reset),
		.push   (pix_push),
		.wdata  (pix_wdata),
		.pop    (pix_pop),
		.rdata  (pix_head),
		.full   (pix_full),
		.empty  (pix_empty),
		.count  (pix_count)
	);

	sync_fifo #(.WIDTH(`SQ_PIX_W), .DEPTH(`SQ_RES_DEPTH)) res_fifo (
		.okClk  (okClk),
		.reset  (reset),
		.push   (res_push),
		.wdata  (res),
		.pop    (res_pop),
		.rdata  (res_head),
		.full   (res_full),
		.empty  (res_empty),
		.count  (res_count)
	);

	apb_host_port u_host (
		.okClk     (okClk),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cmd_push  (cmd_push),
		.cmd_data  (cmd_wdata),
		.cmd_full  (cmd_full),
		.pix_push  (pix_push),
		.pix_data  (pix_wdata),
		.pix_full  (pix_full),
		.pix_count (pix_count),
		.res_pop   (res_pop),
		.res_data  (res_head),
		.res_empty (res_empty),
		.res_count (res_count),
		.done_cnt  (done_cnt)
	);

	// --------------------------------------------------
	// Control and compute
	// --------------------------------------------------
	csb u_csb (
		.okClk     (okClk),
		.reset     (reset),
		.cmd       (cmd_head),
		.cmd_empty (cmd_empty),
		.cmd_pop   (cmd_pop),
		.op_valid  (op_valid),
		.op        (op),
		.op_ready  (op_ready),
		.op_done   (op_done),
		.done_cnt  (done_cnt),
		.irq       (irq)
	);

	pool_engine u_engine (
		.okClk     (okClk),
		.reset     (reset),
		.op_valid  (op_valid),
		.op        (op),
		.op_ready  (op_ready),
		.pix       (pix_head),
		.pix_empty (pix_empty),
		.pix_pop   (pix_pop),
		.res       (res),
		.res_full  (res_full),
		.res_push  (res_push),
		.op_done   (op_done)
	);

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 16
) (
	input  logic                         okClk,
	input  logic                         reset,
	input  logic                         push,
	input  logic [WIDTH-1:0]             wdata,
	input  logic                         pop,
	output logic [WIDTH-1:0]             rdata,
	output logic                         full,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;        // Push while full is dropped
	assign do_pop  = pop && !empty;
	assign full    = (count == CW'(DEPTH));
	assign empty   = (count == '0);
	assign rdata   = mem[rd_ptr];          // Head shows before the pop

	always_ff @(posedge okClk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

`default_nettype wire

/* squeeze_core.f */
+incdir+rtl
rtl/sq_pkg.sv
rtl/sync_fifo.sv
rtl/apb_host_port.sv
rtl/csb.sv
rtl/pool_engine.sv
rtl/sq_top.sv
dv/tb_sq_top.sv
